// File: rtl/mul_params.svh
// the Booth datapath assumes 32-bit operands and both buffer depths must be powers of two
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// operand and tag widths
`define MUL_WIDTH 32
`define MUL_TAG_WIDTH 8
`define MUL_DIGITS 17

// buffers and credits
`define MUL_IN_DEPTH 4
`define MUL_RES_DEPTH 8
`define MUL_OUT_CREDITS 4

`endif

// File: rtl/mulPkg.sv
// payload types for every pipeline stage, sized by the macros in mul_params.svh
`default_nettype none
`include "mul_params.svh"

package mulPkg;

    typedef struct packed {
        logic [`MUL_WIDTH-1:0]     a;
        logic [`MUL_WIDTH-1:0]     b;
        logic                      isSigned;
        logic [`MUL_TAG_WIDTH-1:0] tag;
    } mulReqT;

    // one radix-4 digit, neg is the top bit of its group
    typedef struct packed {
        logic neg;
        logic zero;
        logic one;
        logic two;
    } boothDigitT;

    typedef struct packed {
        logic [`MUL_WIDTH:0]                a;
        boothDigitT [`MUL_DIGITS-1:0]       digits;
        logic                               isSigned;
        logic [`MUL_TAG_WIDTH-1:0]          tag;
    } encodedT;

    typedef struct packed {
        logic [`MUL_DIGITS-1:0][2*`MUL_WIDTH-1:0] row;
        logic [1:0]                               opSign;
        logic                                     isSigned;
        logic [`MUL_TAG_WIDTH-1:0]                tag;
    } ppRowsT;

    typedef struct packed {
        logic [2*`MUL_WIDTH-1:0]   sum;
        logic [2*`MUL_WIDTH-1:0]   carry;
        logic [1:0]                opSign;
        logic                      isSigned;
        logic [`MUL_TAG_WIDTH-1:0] tag;
    } csPairT;

    typedef struct packed {
        logic [2*`MUL_WIDTH-1:0]   product;
        logic                      fits32;
        logic [`MUL_TAG_WIDTH-1:0] tag;
    } mulResT;

endpackage

`default_nettype wire

// File: rtl/boothEncoder.sv
// inValid is legal only while the sender holds a credit and at most one request arrives per cycle
`default_nettype none
`timescale 1ns/1ps
`include "mul_params.svh"

module boothEncoder (
    input  logic            clk,
    input  logic            rstN,
    input  logic            inValid,
    input  mulPkg::mulReqT  inReq,
    input  logic            slotFreed,
    output logic            inCredit,
    output logic            issueValid,
    output mulPkg::encodedT encoded
);
    import mulPkg::*;

    localparam int W = `MUL_WIDTH;
    localparam int PtrW = $clog2(`MUL_IN_DEPTH);
    localparam int CntW = $clog2(`MUL_IN_DEPTH + 1);
    localparam int CredW = $clog2(`MUL_RES_DEPTH + 1);

    mulReqT           reqMem [`MUL_IN_DEPTH];
    logic [PtrW-1:0]  wrPtr;
    logic [PtrW-1:0]  rdPtr;
    logic [CntW-1:0]  reqCount;
    logic [CredW-1:0] issueCredits;
    logic             issue;
    mulReqT           head;
    logic             bExt;
    logic [W+2:0]     bPadded;

    function automatic boothDigitT encodeDigit(input logic [2:0] grp);
        boothDigitT d;
        d.neg  = grp[2];
        d.zero = (grp == 3'b000) || (grp == 3'b111);
        d.one  = grp[1] ^ grp[0];
        d.two  = (grp == 3'b011) || (grp == 3'b100);
        return d;
    endfunction

    // issue needs a queued request and a free result slot
    assign issue    = (reqCount != '0) && (issueCredits != '0);
    assign inCredit = issue;
    assign head     = reqMem[rdPtr];

    // b widened to 34 bits, plus the implicit zero below bit 0
    assign bExt    = head.isSigned & head.b[W-1];
    assign bPadded = {bExt, bExt, head.b, 1'b0};

    always_ff @(posedge clk) begin
        if (inValid) begin
            reqMem[wrPtr] <= inReq;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            reqCount     <= '0;
            issueCredits <= CredW'(`MUL_RES_DEPTH);
            issueValid   <= 1'b0;
        end else begin
            if (inValid) begin
                wrPtr <= wrPtr + PtrW'(1);
            end
            if (issue) begin
                rdPtr <= rdPtr + PtrW'(1);
            end
            reqCount     <= reqCount + CntW'(inValid) - CntW'(issue);
            issueCredits <= issueCredits + CredW'(slotFreed) - CredW'(issue);
            issueValid   <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            encoded.a <= {head.isSigned & head.a[W-1], head.a};
            for (int i = 0; i < `MUL_DIGITS; i++) begin
                encoded.digits[i] <= encodeDigit(bPadded[2*i +: 3]);
            end
            encoded.isSigned <= head.isSigned;
            encoded.tag      <= head.tag;
        end
    end

    // sender overran its credits
    assert property (@(posedge clk) disable iff (!rstN)
        inValid |-> reqCount != CntW'(`MUL_IN_DEPTH))
        else $error("request pushed into a full request buffer");

    assert property (@(posedge clk) disable iff (!rstN)
        issueCredits <= CredW'(`MUL_RES_DEPTH))
        else $error("issue credits above result buffer depth");

endmodule

`default_nettype wire

// File: rtl/partialProductGen.sv
// rows are full 64-bit values at final weight so the reducer needs no extension constants
`default_nettype none
`timescale 1ns/1ps
`include "mul_params.svh"

module partialProductGen (
    input  logic            clk,
    input  logic            rstN,
    input  logic            issueValid,
    input  mulPkg::encodedT encoded,
    output logic            ppValid,
    output mulPkg::ppRowsT  rows
);
    import mulPkg::*;

    localparam int W = `MUL_WIDTH;
    localparam int PW = 2 * W;
    // twice a needs one bit over the 33-bit operand
    localparam int MW = W + 2;

    logic [`MUL_DIGITS-1:0]         negEff;
    logic [`MUL_DIGITS-1:0][PW-1:0] rowsD;

    for (genvar i = 0; i < `MUL_DIGITS; i++) begin : gRow
        boothDigitT    d;
        logic [MW-1:0] mag;
        logic [MW-1:0] inv;
        logic [PW-1:0] ext;

        assign d = encoded.digits[i];
        // the all-ones group is a zero digit even though neg is set
        assign negEff[i] = d.neg & ~d.zero;
        assign mag = d.two ? {encoded.a, 1'b0} :
                     (d.one ? {encoded.a[W], encoded.a} : '0);
        assign inv = mag ^ {MW{negEff[i]}};
        assign ext = {{(PW - MW){inv[MW-1]}}, inv};

        if (i == 0) begin : gFirst
            assign rowsD[i] = ext;
        end else begin : gRest
            // +1 of the previous row fills a free bit below this row
            assign rowsD[i] = (ext << (2 * i)) | (PW'(negEff[i-1]) << (2 * i - 2));
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ppValid <= 1'b0;
        end else begin
            ppValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            rows.row <= rowsD;
            // a sign from the extended operand, b sign from the top digit
            rows.opSign   <= {encoded.a[W], encoded.digits[`MUL_DIGITS-1].neg};
            rows.isSigned <= encoded.isSigned;
            rows.tag      <= encoded.tag;
        end
    end

endmodule

`default_nettype wire

// File: rtl/wallaceReducer.sv
// tree shape is fixed for 17 rows and takes exactly two cycles with no stall
`default_nettype none
`timescale 1ns/1ps
`include "mul_params.svh"

module wallaceReducer (
    input  logic           clk,
    input  logic           rstN,
    input  logic           ppValid,
    input  mulPkg::ppRowsT rows,
    output logic           csValid,
    output mulPkg::csPairT csPair
);
    import mulPkg::*;

    localparam int PW = 2 * `MUL_WIDTH;

    typedef struct packed {
        logic [5:0][PW-1:0]        row;
        logic [1:0]                opSign;
        logic                      isSigned;
        logic [`MUL_TAG_WIDTH-1:0] tag;
    } midT;

    logic [11:0][PW-1:0] lvl1;
    logic [7:0][PW-1:0]  lvl2;
    logic [5:0][PW-1:0]  lvl3;
    logic [3:0][PW-1:0]  lvl4;
    logic [2:0][PW-1:0]  lvl5;
    logic [1:0][PW-1:0]  lvl6;
    midT                 mid;
    logic                midValid;

    // 3:2 compressor across the whole row, sum above carry
    function automatic logic [2*PW-1:0] csa(input logic [PW-1:0] x, y, z);
        logic [PW-1:0] s;
        logic [PW-1:0] c;
        s = x ^ y ^ z;
        c = ((x & y) | (x & z) | (y & z)) << 1;
        return {s, c};
    endfunction

    // 17 -> 12 -> 8 -> 6
    always_comb begin
        for (int j = 0; j < 5; j++) begin
            {lvl1[2*j+1], lvl1[2*j]} = csa(rows.row[3*j], rows.row[3*j+1], rows.row[3*j+2]);
        end
        lvl1[11:10] = rows.row[16:15];
        for (int j = 0; j < 4; j++) begin
            {lvl2[2*j+1], lvl2[2*j]} = csa(lvl1[3*j], lvl1[3*j+1], lvl1[3*j+2]);
        end
        for (int j = 0; j < 2; j++) begin
            {lvl3[2*j+1], lvl3[2*j]} = csa(lvl2[3*j], lvl2[3*j+1], lvl2[3*j+2]);
        end
        lvl3[5:4] = lvl2[7:6];
    end

    // 6 -> 4 -> 3 -> 2
    always_comb begin
        for (int j = 0; j < 2; j++) begin
            {lvl4[2*j+1], lvl4[2*j]} = csa(mid.row[3*j], mid.row[3*j+1], mid.row[3*j+2]);
        end
        {lvl5[1], lvl5[0]} = csa(lvl4[0], lvl4[1], lvl4[2]);
        lvl5[2] = lvl4[3];
        {lvl6[1], lvl6[0]} = csa(lvl5[0], lvl5[1], lvl5[2]);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            midValid <= 1'b0;
            csValid  <= 1'b0;
        end else begin
            midValid <= ppValid;
            csValid  <= midValid;
        end
    end

    always_ff @(posedge clk) begin
        if (ppValid) begin
            mid.row      <= lvl3;
            mid.opSign   <= rows.opSign;
            mid.isSigned <= rows.isSigned;
            mid.tag      <= rows.tag;
        end
        if (midValid) begin
            csPair.sum      <= lvl6[1];
            csPair.carry    <= lvl6[0];
            csPair.opSign   <= mid.opSign;
            csPair.isSigned <= mid.isSigned;
            csPair.tag      <= mid.tag;
        end
    end

endmodule

`default_nettype wire

// File: rtl/resultDrain.sv
// the receiver must take every result on the cycle outValid is high and outRes is valid only then
`default_nettype none
`timescale 1ns/1ps
`include "mul_params.svh"

module resultDrain (
    input  logic           clk,
    input  logic           rstN,
    input  logic           csValid,
    input  mulPkg::csPairT csPair,
    input  logic           outCredit,
    output logic           slotFreed,
    output logic           outValid,
    output mulPkg::mulResT outRes
);
    import mulPkg::*;

    localparam int W = `MUL_WIDTH;
    localparam int PW = 2 * W;
    localparam int PtrW = $clog2(`MUL_RES_DEPTH);
    localparam int CntW = $clog2(`MUL_RES_DEPTH + 1);
    localparam int CredW = $clog2(`MUL_OUT_CREDITS + 1);

    mulResT           resMem [`MUL_RES_DEPTH];
    logic [PtrW-1:0]  wrPtr;
    logic [PtrW-1:0]  rdPtr;
    logic [CntW-1:0]  resCount;
    logic [CredW-1:0] outCredits;
    logic [PW-1:0]    prod;
    logic [W:0]       hiSigned;
    logic             fits;
    logic             send;

    // final carry-propagate add
    assign prod = csPair.sum + csPair.carry;

    // signed fit needs bits 63..31 all equal
    assign hiSigned = prod[PW-1:W-1];
    assign fits = csPair.isSigned ? ((&hiSigned) | ~(|hiSigned)) : ~(|prod[PW-1:W]);

    assign send      = (resCount != '0) && (outCredits != '0);
    assign outValid  = send;
    assign slotFreed = send;
    assign outRes    = resMem[rdPtr];

    always_ff @(posedge clk) begin
        if (csValid) begin
            resMem[wrPtr] <= '{product: prod, fits32: fits, tag: csPair.tag};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            resCount   <= '0;
            outCredits <= CredW'(`MUL_OUT_CREDITS);
        end else begin
            if (csValid) begin
                wrPtr <= wrPtr + PtrW'(1);
            end
            if (send) begin
                rdPtr <= rdPtr + PtrW'(1);
            end
            resCount   <= resCount + CntW'(csValid) - CntW'(send);
            outCredits <= outCredits + CredW'(outCredit) - CredW'(send);
        end
    end

    // issue credits upstream should make this impossible
    assert property (@(posedge clk) disable iff (!rstN)
        csValid |-> resCount != CntW'(`MUL_RES_DEPTH))
        else $error("result written into a full buffer");

    assert property (@(posedge clk) disable iff (!rstN)
        outCredits <= CredW'(`MUL_OUT_CREDITS))
        else $error("receiver returned more credits than it was given");

    // nonzero signed product must carry the xor of the operand signs
    assert property (@(posedge clk) disable iff (!rstN)
        (csValid && csPair.isSigned && prod != '0) |-> prod[PW-1] == ^csPair.opSign)
        else $error("signed product has the wrong sign");

endmodule

`default_nettype wire

// File: rtl/boothMultiplier.sv
// latency from request to result varies with credits and is at least 6 cycles when idle
`default_nettype none
`timescale 1ns/1ps

module boothMultiplier (
    input  logic           clk,
    input  logic           rstN,
    input  logic           inValid,
    input  mulPkg::mulReqT inReq,
    output logic           inCredit,
    output logic           outValid,
    output mulPkg::mulResT outRes,
    input  logic           outCredit
);
    import mulPkg::*;

    logic    issueValid;
    encodedT encoded;
    logic    ppValid;
    ppRowsT  rows;
    logic    csValid;
    csPairT  csPair;
    // internal issue credit from the drain
    logic    slotFreed;

    boothEncoder uEncoder (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .inReq      (inReq),
        .slotFreed  (slotFreed),
        .inCredit   (inCredit),
        .issueValid (issueValid),
        .encoded    (encoded)
    );

    partialProductGen uPpGen (
        .clk        (clk),
        .rstN       (rstN),
        .issueValid (issueValid),
        .encoded    (encoded),
        .ppValid    (ppValid),
        .rows       (rows)
    );

    wallaceReducer uReducer (
        .clk     (clk),
        .rstN    (rstN),
        .ppValid (ppValid),
        .rows    (rows),
        .csValid (csValid),
        .csPair  (csPair)
    );

    resultDrain uDrain (
        .clk       (clk),
        .rstN      (rstN),
        .csValid   (csValid),
        .csPair    (csPair),
        .outCredit (outCredit),
        .slotFreed (slotFreed),
        .outValid  (outValid),
        .outRes    (outRes)
    );

endmodule

`default_nettype wire

// File: sim/tbMultiplier.sv
// stimulus and credit returns are random from one fixed seed so every run repeats
`default_nettype none
`timescale 1ns/1ps
`include "mul_params.svh"

module tbMultiplier;
    import mulPkg::*;

    localparam int Timeout = 2000;

    logic   clk = 1'b0;
    logic   rstN = 1'b0;
    logic   inValid = 1'b0;
    mulReqT inReq = '0;
    logic   inCredit;
    logic   outValid;
    mulResT outRes;
    logic   outCredit = 1'b0;

    mulReqT      expQ [$];
    logic        withhold = 1'b0;
    logic [7:0]  nextTag = 8'd0;
    int          sentCount = 0;
    int          creditsIn = 0;
    int          outCount = 0;
    int          creditsBack = 0;
    int          held = 0;
    logic [31:0] corners [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

    boothMultiplier u_dut (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inReq     (inReq),
        .inCredit  (inCredit),
        .outValid  (outValid),
        .outRes    (outRes),
        .outCredit (outCredit)
    );

    always #5 clk = ~clk;

    // expected result from plain 64-bit arithmetic
    function automatic mulResT refMul(input mulReqT r);
        logic signed [63:0] x;
        logic signed [63:0] y;
        logic signed [63:0] p;
        mulResT res;
        x = r.isSigned ? {{32{r.a[31]}}, r.a} : {32'd0, r.a};
        y = r.isSigned ? {{32{r.b[31]}}, r.b} : {32'd0, r.b};
        p = x * y;
        res.product = p;
        if (r.isSigned) begin
            res.fits32 = (p >= -64'sd2147483648) && (p <= 64'sd2147483647);
        end else begin
            res.fits32 = $unsigned(p) < 64'h1_0000_0000;
        end
        res.tag = r.tag;
        return res;
    endfunction

    task automatic failNow(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s got %h expected %h", $time, what, got, exp);
            failNow("stopping at the first mismatch");
        end
    endtask

    // sends one request per edge while credits last
    task automatic sendReq(input mulReqT r);
        int cycles;
        cycles = 0;
        while (`MUL_IN_DEPTH + creditsIn - sentCount <= 0) begin
            inValid <= 1'b0;
            @(posedge clk);
            cycles++;
            if (cycles > Timeout) begin
                failNow("timed out waiting for an input credit");
            end
        end
        inValid <= 1'b1;
        inReq   <= r;
        sentCount++;
        expQ.push_back(r);
        @(posedge clk);
    endtask

    task automatic sendOp(input logic [31:0] a, input logic [31:0] b, input logic s);
        mulReqT r;
        r.a        = a;
        r.b        = b;
        r.isSigned = s;
        r.tag      = nextTag;
        nextTag    = nextTag + 8'd1;
        sendReq(r);
    endtask

    task automatic idle(input int n);
        inValid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic waitDrain();
        int cycles;
        cycles = 0;
        inValid <= 1'b0;
        while (outCount != sentCount || held != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > Timeout) begin
                failNow("timed out waiting for all results to drain");
            end
        end
    endtask

    always @(posedge clk) begin
        if (rstN && inCredit) begin
            creditsIn <= creditsIn + 1;
        end
    end

    // receiver model and result comparison
    always @(posedge clk) begin
        mulReqT req;
        mulResT exp;
        int     heldNext;
        if (!rstN) begin
            outCredit <= 1'b0;
        end else begin
            heldNext = held;
            if (outValid) begin
                checkEq(64'(outCount + 1 <= creditsBack + `MUL_OUT_CREDITS), 64'd1,
                    "result sent without a downstream credit");
                if (expQ.size() == 0) begin
                    failNow("a result arrived with no request outstanding");
                end
                req = expQ.pop_front();
                exp = refMul(req);
                checkEq(64'(outRes.tag), 64'(exp.tag), "tag");
                checkEq(outRes.product, exp.product, "product");
                checkEq(64'(outRes.fits32), 64'(exp.fits32), "fits32");
                outCount <= outCount + 1;
                heldNext++;
            end
            if (heldNext > 0 && !withhold && $urandom_range(0, 3) != 0) begin
                outCredit   <= 1'b1;
                creditsBack <= creditsBack + 1;
                heldNext--;
            end else begin
                outCredit <= 1'b0;
            end
            held <= heldNext;
        end
    end

    initial begin
        int outBase;
        void'($urandom(32'hcc2e4c7f));
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);

        // random signed requests and then unsigned ones with the top bit often set
        for (int i = 0; i < 40; i++) begin
            sendOp($urandom, $urandom, 1'b1);
        end
        for (int i = 0; i < 40; i++) begin
            sendOp($urandom | ((i % 2 == 0) ? 32'h8000_0000 : 32'h0), $urandom, 1'b0);
        end

        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    sendOp(corners[i], corners[j], s[0]);
                end
            end
        end

        // fit boundaries in signed and then unsigned mode
        sendOp(32'd46340, 32'd46340, 1'b1);
        sendOp(32'd46341, 32'd46341, 1'b1);
        sendOp(32'd65536, 32'd32767, 1'b1);
        sendOp(32'd65536, 32'd32768, 1'b1);
        sendOp(-32'sd65536, 32'd32768, 1'b1);
        sendOp(-32'sd65536, 32'd32769, 1'b1);
        sendOp(32'd65536, 32'd65535, 1'b0);
        sendOp(32'd65536, 32'd65536, 1'b0);
        sendOp(32'hffff_ffff, 32'd1, 1'b0);
        sendOp(32'hffff_ffff, 32'd2, 1'b0);
        waitDrain();

        // receiver holds its credits for a while
        outBase = outCount;
        withhold <= 1'b1;
        for (int i = 0; i < 12; i++) begin
            sendOp($urandom, $urandom, i[0]);
        end
        idle(40);
        checkEq(64'(outCount - outBase <= `MUL_OUT_CREDITS), 64'd1,
            "results sent while credits were withheld");
        withhold <= 1'b0;
        for (int i = 0; i < 20; i++) begin
            sendOp($urandom, $urandom, i[0]);
        end
        waitDrain();

        checkEq(64'(creditsIn), 64'(sentCount), "inCredit pulses against requests sent");
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+rtl
rtl/mulPkg.sv
rtl/boothEncoder.sv
rtl/partialProductGen.sv
rtl/wallaceReducer.sv
rtl/resultDrain.sv
rtl/boothMultiplier.sv
sim/tbMultiplier.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tbMultiplier -o simv

# the simulator exits nonzero on a fatal, the log decides the result
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -qF "** FAIL **" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -qF "** PASS **" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
